// ==== filtered_line_buffer.sv ====
module filtered_line_buffer
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              fill_kick,
    input  nabp_pkg::sample_t hs_val,
    input  nabp_pkg::s_val_t  pr0_s_val,
    input  nabp_pkg::s_val_t  pr1_s_val,
    output logic              fill_done,
    output nabp_pkg::s_val_t  hs_s_val,
    output nabp_pkg::sample_t pr0_val,
    output nabp_pkg::sample_t pr1_val
);

    import nabp_pkg::*;

    s_val_t  write_addr;
    s_val_t  pr0_addr;
    logic    write_enable;
    logic    fill_busy;
    logic    filter_clear;
    sample_t filtered_sample;

    // input side, host fetch and write sequencing
    filtered_ram_fill_control fill_control
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .fill_kick    (fill_kick),
        .hs_s_val     (hs_s_val),
        .write_addr   (write_addr),
        .write_enable (write_enable),
        .fill_busy    (fill_busy),
        .filter_clear (filter_clear),
        .fill_done    (fill_done)
    );

    // processing, ramp filter on the host stream
    ramp_fir_filter fir
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .clear      (filter_clear),
        .sample_in  (hs_val),
        .sample_out (filtered_sample)
    );

    // port 0 belongs to the fill while busy
    assign pr0_addr = fill_busy ? write_addr : pr0_s_val;

    // output side, line storage for the two processing units
    filtered_line_ram line_ram
    (
        .clk        (clk),
        .we_0       (write_enable),
        .addr_0     (pr0_addr),
        .data_in_0  (filtered_sample),
        .addr_1     (pr1_s_val),
        .data_out_0 (pr0_val),
        .data_out_1 (pr1_val)
    );

endmodule

// ==== filtered_line_buffer_assertions.sv ====
`include "nabp_settings.svh"

module filtered_line_buffer_assertions
(
    input logic             clk,
    input logic             reset_n,
    input logic             fill_kick,
    input logic             fill_busy,
    input logic             fill_done,
    input nabp_pkg::s_val_t hs_s_val
);

    import nabp_pkg::*;

    localparam int line_last = `NABP_LINE_SIZE - 1;

    // failed assertions so far
    int fail_count = 0;

    // accepted kick whose done is still due
    logic kick_open;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            kick_open <= 1'b0;
        else if (fill_kick && !fill_busy)
            kick_open <= 1'b1;
        else if (fill_done)
            kick_open <= 1'b0;
    end

    done_single_pulse: assert property (@(posedge clk) disable iff (reset_n)
        fill_done |=> !fill_done)
    else
    begin
        $error("fill_done stayed high for more than one cycle");
        fail_count++;
    end

    done_needs_kick: assert property (@(posedge clk) disable iff (reset_n)
        $rose(fill_done) |-> kick_open)
    else
    begin
        $error("fill_done rose with no accepted kick before it");
        fail_count++;
    end

    // host address parks on the line end, no wrap before the fill ends
    read_addr_holds_at_end: assert property (@(posedge clk) disable iff (reset_n)
        (fill_busy && !fill_done && int'(hs_s_val) == line_last)
            |=> int'(hs_s_val) == line_last)
    else
    begin
        $error("hs_s_val moved past the last line address");
        fail_count++;
    end

    done_low_after_reset: assert property (@(posedge clk)
        reset_n |=> !fill_done)
    else
    begin
        $error("fill_done high right after reset");
        fail_count++;
    end

endmodule

bind filtered_line_buffer filtered_line_buffer_assertions checks
(
    .clk       (clk),
    .reset_n   (reset_n),
    .fill_kick (fill_kick),
    .fill_busy (fill_busy),
    .fill_done (fill_done),
    .hs_s_val  (hs_s_val)
);

// ==== filtered_line_buffer_tb.sv ====
`include "nabp_settings.svh"

module filtered_line_buffer_tb;

    import nabp_pkg::*;

    localparam int line_last    = `NABP_LINE_SIZE - 1;
    localparam int reset_cycles = 10;
    // kick, filter delay, one write per sample and some slack
    localparam int fill_cycles  = `NABP_LINE_SIZE + `NABP_FIR_ORDER + 8;
    localparam int random_reads = 64;
    // three tested fills and one ignored kick, all reads and gaps, ten times over
    localparam int timeout_cycles = 10 * (reset_cycles + 8 * fill_cycles
        + 4 * `NABP_LINE_SIZE + random_reads + 40);

    logic    clk = 1'b0;
    logic    reset_n;
    logic    fill_kick;
    sample_t hs_val;
    s_val_t  pr0_s_val;
    s_val_t  pr1_s_val;
    logic    fill_done;
    s_val_t  hs_s_val;
    sample_t pr0_val;
    sample_t pr1_val;

    // host sample memory and the filtered line it should give
    sample_t host_mem [0:line_last];
    sample_t expected_line [0:line_last];

    integer seed = 86;
    int     data_errors = 0;
    int     event_errors = 0;
    int     done_count = 0;
    int     done_before;
    int     cycle_count = 0;
    int     total_errors;

    filtered_line_buffer dut
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .fill_kick (fill_kick),
        .hs_val    (hs_val),
        .pr0_s_val (pr0_s_val),
        .pr1_s_val (pr1_s_val),
        .fill_done (fill_done),
        .hs_s_val  (hs_s_val),
        .pr0_val   (pr0_val),
        .pr1_val   (pr1_val)
    );

    always #5 clk = ~clk;

    // host answers one cycle after the address
    always @(posedge clk)
    begin
        hs_val <= host_mem[hs_s_val];
    end

    always @(negedge clk)
    begin
        if (!reset_n && fill_done)
            done_count++;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the run went past %0d cycles", timeout_cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("** Error: %s expected %0d, actual %0d", name, expected, actual);
            data_errors++;
        end
    endtask

    // new random line, expected result from the ramp kernel
    task automatic load_host();
        int sum;
        int idx;
        int raw;
        for (int i = 0; i <= line_last; i++)
            host_mem[i] = sample_t'($random(seed));
        for (int k = 0; k <= line_last; k++)
        begin
            sum = 0;
            for (int j = 0; j <= `NABP_FIR_ORDER; j++)
            begin
                idx = k + `NABP_FIR_ORDER / 2 - j;
                // zero before the line start, last sample repeats past the end
                if (idx < 0)
                    raw = 0;
                else if (idx > line_last)
                    raw = int'(host_mem[line_last]);
                else
                    raw = int'(host_mem[idx]);
                sum = sum + int'(fir_taps[j]) * raw;
            end
            expected_line[k] = sample_t'(sum);
        end
    endtask

    task automatic kick();
        @(posedge clk);
        fill_kick <= 1'b1;
        @(posedge clk);
        fill_kick <= 1'b0;
    endtask

    task automatic wait_fill_done(input string name);
        int  n;
        bit  seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 2 * fill_cycles)
        begin
            @(negedge clk);
            seen = fill_done;
            n++;
        end
        if (!seen)
        begin
            $display("%s: fill_done did not arrive within %0d cycles", name, n);
            event_errors++;
        end
    endtask

    // back-to-back reads on both ports, each result checked one cycle later
    task automatic check_reads(input string name, input int count, input bit random_addr);
        s_val_t a0;
        s_val_t a1;
        s_val_t prev0;
        s_val_t prev1;
        prev0 = '0;
        prev1 = '0;
        for (int n = 0; n <= count; n++)
        begin
            if (random_addr)
            begin
                a0 = s_val_t'($random(seed));
                a1 = s_val_t'($random(seed));
            end
            else
            begin
                a0 = s_val_t'(n);
                a1 = s_val_t'(line_last - n);
            end
            @(posedge clk);
            pr0_s_val <= a0;
            pr1_s_val <= a1;
            @(negedge clk);
            if (n > 0)
            begin
                check_value($sformatf("%s pr0[%0d]", name, prev0),
                    int'(expected_line[prev0]), int'(pr0_val));
                check_value($sformatf("%s pr1[%0d]", name, prev1),
                    int'(expected_line[prev1]), int'(pr1_val));
            end
            prev0 = a0;
            prev1 = a1;
        end
    endtask

    initial
    begin
        reset_n   = 1'b1;
        fill_kick = 1'b0;
        hs_val    = '0;
        pr0_s_val = '0;
        pr1_s_val = '0;
        load_host();
        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b0;

        // idle after reset
        repeat (20)
        begin
            @(negedge clk);
            check_value("reset state fill_done", 0, int'(fill_done));
            check_value("reset state hs_s_val", 0, int'(hs_s_val));
        end

        kick();
        wait_fill_done("single fill");
        check_reads("single fill", `NABP_LINE_SIZE, 1'b0);

        check_reads("dual-port reads", random_reads, 1'b1);

        load_host();
        kick();
        wait_fill_done("refill");
        check_reads("refill", `NABP_LINE_SIZE, 1'b0);

        // second kick lands in the first fill cycle
        load_host();
        done_before = done_count;
        kick();
        repeat (3) @(posedge clk);
        fill_kick <= 1'b1;
        @(posedge clk);
        fill_kick <= 1'b0;
        wait_fill_done("kick while busy");
        repeat (fill_cycles) @(negedge clk);
        check_value("kick while busy done count", 1, done_count - done_before);
        check_reads("kick while busy", `NABP_LINE_SIZE, 1'b0);

        total_errors = data_errors + event_errors + dut.checks.fail_count;
        $display("errors: %0d data, %0d event, %0d assertion",
            data_errors, event_errors, dut.checks.fail_count);
        if (total_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== filtered_line_ram.sv ====
`include "nabp_settings.svh"

module filtered_line_ram
(
    input  logic              clk,
    input  logic              we_0,
    input  nabp_pkg::s_val_t  addr_0,
    input  nabp_pkg::sample_t data_in_0,
    input  nabp_pkg::s_val_t  addr_1,
    output nabp_pkg::sample_t data_out_0,
    output nabp_pkg::sample_t data_out_1
);

    import nabp_pkg::*;

    sample_t mem [0:`NABP_LINE_SIZE-1];

    // port 0, write with read of the old word
    always_ff @(posedge clk)
    begin
        if (we_0)
            mem[addr_0] <= data_in_0;
        data_out_0 <= mem[addr_0];
    end

    // port 1, read only
    always_ff @(posedge clk)
    begin
        data_out_1 <= mem[addr_1];
    end

endmodule

// ==== filtered_ram_fill_control.sv ====
`include "nabp_settings.svh"

module filtered_ram_fill_control
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             fill_kick,
    output nabp_pkg::s_val_t hs_s_val,
    output nabp_pkg::s_val_t write_addr,
    output logic             write_enable,
    output logic             fill_busy,
    output logic             filter_clear,
    output logic             fill_done
);

    import nabp_pkg::*;

    // last address of a line
    localparam s_val_t line_last = s_val_t'(`NABP_LINE_SIZE - 1);

    // The read side must lead the write side by the host read cycle, the
    // filter output register and half the filter order. Leaving delay at this
    // read count puts read address 4 against write address 0 in the first
    // fill cycle.
    localparam s_val_t delay_end = s_val_t'(`NABP_FIR_ORDER / 2 + 1);

    fill_state_t state;
    fill_state_t next_state;
    s_val_t      read_itr;
    s_val_t      write_itr;
    logic        delay_done;

    always_ff @(posedge clk)
    begin
        if (reset_n)
            state <= ready;
        else
            state <= next_state;
    end

    assign delay_done = (read_itr == delay_end);

    always_comb
    begin
        next_state = state;
        case (state)
            ready:
                if (fill_kick)
                    next_state = delay;
            delay:
                if (delay_done)
                    next_state = fill;
            fill:
                if (write_itr == line_last)
                    next_state = ready;
            default:
                next_state = ready;
        endcase
    end

    // read and write iterators
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            read_itr  <= '0;
            write_itr <= '0;
        end
        else
        begin
            case (state)
                ready:
                begin
                    // address 0 goes out in the kick cycle itself
                    read_itr  <= fill_kick ? s_val_t'(1) : '0;
                    write_itr <= '0;
                end
                delay:
                    read_itr <= read_itr + s_val_t'(1);
                fill:
                    if (next_state == ready)
                    begin
                        // park on address 0 so a new kick starts clean
                        read_itr  <= '0;
                        write_itr <= '0;
                    end
                    else
                    begin
                        write_itr <= write_itr + s_val_t'(1);
                        // hold at the line end, last sample repeats
                        if (read_itr != line_last)
                            read_itr <= read_itr + s_val_t'(1);
                    end
                default:
                begin
                    read_itr  <= '0;
                    write_itr <= '0;
                end
            endcase
        end
    end

    assign hs_s_val     = read_itr;
    assign write_addr   = write_itr;
    assign write_enable = (state == fill);
    assign fill_busy    = (state != ready);
    assign filter_clear = (state == ready) && fill_kick;

    // mealy done, high during the last write
    assign fill_done = (state == fill) && (next_state == ready);

endmodule

// ==== nabp_pkg.sv ====
`include "nabp_settings.svh"

package nabp_pkg;

    // address into a projection line
    typedef logic [`NABP_S_LENGTH-1:0] s_val_t;

    // raw host sample or filtered sample, two's complement
    typedef logic signed [`NABP_DATA_LENGTH-1:0] sample_t;

    // fill controller states
    typedef enum logic [1:0]
    {
        ready,
        delay,
        fill
    } fill_state_t;

    // small signed filter coefficient
    typedef logic signed [3:0] tap_t;

    // symmetric ramp kernel, index 0 multiplies the newest sample
    localparam tap_t fir_taps [0:`NABP_FIR_ORDER] =
        '{-4'sd1, 4'sd0, 4'sd2, 4'sd0, -4'sd1};

endpackage

// ==== nabp_settings.svh ====
`ifndef NABP_SETTINGS_SVH
`define NABP_SETTINGS_SVH

// samples in one projection line
`define NABP_LINE_SIZE 16

// line address width, wide enough for NABP_LINE_SIZE entries
`define NABP_S_LENGTH 4

// host and filtered sample width
`define NABP_DATA_LENGTH 12

// ramp filter order, taps = order + 1
`define NABP_FIR_ORDER 4

`endif

// ==== ramp_fir_filter.sv ====
`include "nabp_settings.svh"

module ramp_fir_filter
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              clear,
    input  nabp_pkg::sample_t sample_in,
    output nabp_pkg::sample_t sample_out
);

    import nabp_pkg::*;

    localparam int order = `NABP_FIR_ORDER;

    // product of sample and tap plus growth for order + 1 terms
    localparam int acc_width = `NABP_DATA_LENGTH + $bits(tap_t) + $clog2(order + 1);

    // history[0] is the previous sample, history[order-1] the oldest
    sample_t history [0:order-1];

    logic signed [acc_width-1:0] acc;

    // multiply-accumulate over the current sample and the history
    always_comb
    begin
        acc = fir_taps[0] * sample_in;
        for (int j = 1; j <= order; j++)
        begin
            acc = acc + fir_taps[j] * history[j-1];
        end
    end

    // sample shift register
    always_ff @(posedge clk)
    begin
        if (reset_n || clear)
        begin
            // samples ahead of a line start count as zero
            for (int i = 0; i < order; i++)
            begin
                history[i] <= '0;
            end
        end
        else
        begin
            history[0] <= sample_in;
            for (int i = 1; i < order; i++)
            begin
                history[i] <= history[i-1];
            end
        end
    end

    // output register, low bits of the sum
    always_ff @(posedge clk)
    begin
        if (reset_n || clear)
            sample_out <= '0;
        else
            sample_out <= sample_t'(acc[`NABP_DATA_LENGTH-1:0]);
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the line buffer testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f \
    --top-module filtered_line_buffer_tb -o filtered_line_buffer_sim

./obj_dir/filtered_line_buffer_sim 2>&1 | tee sim.log

if grep -qx "PASS: all tests" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== vlog.f ====
+incdir+.
nabp_pkg.sv
filtered_ram_fill_control.sv
ramp_fir_filter.sv
filtered_line_ram.sv
filtered_line_buffer.sv
filtered_line_buffer_assertions.sv
filtered_line_buffer_tb.sv
